/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := endpoint_tb
FILELIST := endpoint.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/endpoint_checker.sv */
`timescale 1ns/1ns

module endpoint_checker
    import chiplet_types_pkg::*;
    import endpoint_map_pkg::*;
(
    input logic     clk,
    input logic     n_rst,
    input bus_req_t req,
    input bus_rsp_t rsp,
    input logic     fill_ready
);

    logic        active;
    logic        rx_target;
    logic        cache_read;
    int unsigned fail_count = 0;

    assign active    = req.ren || req.wen;
    assign rx_target = active && (req.addr >= RX_CACHE_BASE)
                       && (req.addr < RX_CACHE_BASE + CACHE_LEN);
    assign cache_read = req.ren && (rx_target || ((req.addr >= TX_CACHE_BASE)
                        && (req.addr < TX_CACHE_BASE + CACHE_LEN)));

    stall_has_request: assert property (
        @(posedge clk) disable iff (!n_rst) rsp.request_stall |-> active
    ) else begin
        $error("request_stall raised with no request active");
        fail_count++;
    end

    // master owns the rx cache while it accesses it.
    rx_blocks_fill: assert property (
        @(posedge clk) disable iff (!n_rst) rx_target |-> !fill_ready
    ) else begin
        $error("fill_ready high during an rx region access");
        fail_count++;
    end

    stall_one_cycle: assert property (
        @(posedge clk) disable iff (!n_rst) rsp.request_stall |=> !rsp.request_stall
    ) else begin
        $error("cache read stalled for more than one cycle");
        fail_count++;
    end

    // a new cache read always starts with its one stall cycle.
    stall_first_cycle: assert property (
        @(posedge clk) disable iff (!n_rst)
        cache_read && !$past(rsp.request_stall) |-> rsp.request_stall
    ) else begin
        $error("cache read did not stall in its first cycle");
        fail_count++;
    end

endmodule

bind endpoint endpoint_checker u_endpoint_checker (
    .clk        (clk),
    .n_rst      (n_rst),
    .req        (req),
    .rsp        (rsp),
    .fill_ready (fill_ready)
);

/* bench/endpoint_tb.sv */
`timescale 1ns/1ns

module endpoint_tb
    import chiplet_types_pkg::*;
();

    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 16;

    logic      clk        = 1'b0;
    logic      n_rst      = 1'b0;
    bus_req_t  req        = '0;
    bus_rsp_t  rsp;
    logic      fill_valid = 1'b0;
    logic      fill_ready;
    fill_req_t fill       = '0;
    bus_rsp_t  rsp_seen;
    int        errors     = 0;
    int        checks     = 0;
    logic      timed_out  = 1'b0;

    endpoint u_endpoint (.*);

    always #10 clk = ~clk;

    // outputs and fill_ready taken at the falling edge.
    task automatic next_cycle;
        logic take;
        @(negedge clk);
        rsp_seen = rsp;
        take     = fill_valid && fill_ready;
        @(posedge clk);
        #DRIVE_DELAY;
        if (take) begin
            fill_valid = 1'b0;
        end
    endtask

    task automatic drain_fill(input string name);
        int waited;
        waited = 0;
        while (fill_valid && waited < WAIT_LIMIT) begin
            waited++;
            next_cycle();
        end
        if (fill_valid) begin
            $display("timeout: fill word never accepted before %s", name);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_access(input logic [7:0] op, input bus_addr_t addr, input word_t data,
            input strobe_t strb, input word_t exp_rdata, input logic exp_err, input string name);
        int waited;
        req    = '{wen: op == "W", ren: op == "R", addr: addr, wdata: data, strobe: strb};
        waited = 0;
        next_cycle();
        // hold the request until the stall drops.
        while (rsp_seen.request_stall && waited < WAIT_LIMIT) begin
            waited++;
            next_cycle();
        end
        req = '0;
        if (rsp_seen.request_stall) begin
            $display("timeout: %s still stalled after %0d cycles", name, waited);
            errors++;
            timed_out = 1'b1;
        end else begin
            checks++;
            assert (rsp_seen.error === exp_err) else begin
                errors++;
                $display("mismatch %s: error expected %b, actual %b", name, exp_err,
                         rsp_seen.error);
            end
            checks++;
            assert (op != "R" || rsp_seen.rdata === exp_rdata) else begin
                errors++;
                $display("mismatch %s: rdata expected %h, actual %h", name, exp_rdata,
                         rsp_seen.rdata);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data file loop.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int         fd;
        int         got;
        int         line_no;
        string      line;
        logic [7:0] op;
        bus_addr_t  addr;
        word_t      data;
        strobe_t    strb;
        word_t      exp_rdata;
        logic       exp_err;

        line_no = 0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        n_rst = 1'b1;

        fd = $fopen("bench/endpoint_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            errors++;
        end
        while (fd != 0 && !$feof(fd) && !timed_out) begin
            line = "";
            got  = $fgets(line, fd);
            line_no++;
            got  = $sscanf(line, "%c %h %h %h %h %h", op, addr, data, strb, exp_rdata, exp_err);
            if (got == 6 && op == "F") begin
                // posted, taken at the first edge with fill_ready high.
                drain_fill($sformatf("line %0d", line_no));
                fill       = '{addr: cache_addr_t'(addr), data: data};
                fill_valid = !timed_out;
            end else if (got == 6) begin
                run_access(op, addr, data, strb, exp_rdata, exp_err,
                           $sformatf("line %0d %c %h", line_no, op, addr));
            end
        end
        if (!timed_out) begin
            drain_fill("the end of the data");
        end

        // protocol assertion failures from the bound checker.
        errors += u_endpoint.u_endpoint_checker.fail_count;

        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* bench/endpoint_testdata.txt */
# op addr data strobe exp_rdata exp_error, all hex; rdata is checked on R lines only
# op R reads, W writes, F offers a fill word at a cache byte address
R 00000008 00000000 f 00000000 0
W 00000004 00001237 f 00000000 0
R 00000004 00000000 f 00000034 0
W 0000000c 0000ffff f 00000000 0
R 0000000c 00000000 f 000001fc 0
W 00002010 11223344 f 00000000 0
W 00002010 aabbccdd 3 00000000 0
R 00002010 00000000 f 1122ccdd 0
W 000021fc 5a5a5a5a f 00000000 0
W 000021fc a5a5a5a5 8 00000000 0
R 000021fc 00000000 f a55a5a5a 0
F 00000004 12345678 0 00000000 0
R 00000000 00000000 f 00000000 0
R 00003004 00000000 f 12345678 0
W 00003004 ffffffff f 00000000 1
R 00003004 00000000 f 12345678 0
R 00001000 00000000 f bad1bad1 0
R 00002200 00000000 f bad1bad1 0
R 00000010 00000000 f bad1bad1 0
R 00003200 00000000 f bad1bad1 0
W 00001000 01010101 f 00000000 0
# fill waits out the rx read, lands during the packet table read
F 00000010 cafef00d 0 00000000 0
R 00003004 00000000 f 12345678 0
R 00000004 00000000 f 00000034 0
R 00003010 00000000 f cafef00d 0

/* endpoint.f */
logic/chiplet_types_pkg.sv
logic/endpoint_map_pkg.sv
logic/cache.sv
logic/pkt_addr_regs.sv
logic/rx_fill_arb.sv
logic/endpoint.sv
bench/endpoint_checker.sv
bench/endpoint_tb.sv

/* logic/cache.sv */
`timescale 1ns/1ns

module cache
    import chiplet_types_pkg::*;
    import endpoint_map_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  cache_req_t req,
    output bus_rsp_t   rsp,
    input  logic       fill_wen,
    input  fill_req_t  fill
);

    word_t mem [CACHE_NUM_WORDS];
    word_t rdata_q;
    logic  pending_q;
    logic  read_start;

    logic [$clog2(CACHE_NUM_WORDS)-1:0] bus_idx;
    logic [$clog2(CACHE_NUM_WORDS)-1:0] fill_idx;

    // word index, byte offset dropped.
    assign bus_idx  = req.addr[$bits(cache_addr_t)-1:2];
    assign fill_idx = fill.addr[$bits(cache_addr_t)-1:2];

    // first cycle of a read.
    assign read_start = req.ren && !pending_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (req.wen) begin
            for (int i = 0; i < $bits(strobe_t); i++) begin
                if (req.strobe[i]) begin
                    mem[bus_idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end else if (fill_wen) begin
            mem[fill_idx] <= fill.data;
        end

        if (read_start) begin
            rdata_q <= mem[bus_idx];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read stall.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // set for exactly one cycle per read.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= read_start;
        end
    end

    always_comb begin
        rsp.rdata         = rdata_q;
        rsp.error         = 1'b0;
        rsp.request_stall = read_start;
    end

endmodule

/* logic/chiplet_types_pkg.sv */
package chiplet_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;
    typedef logic [31:0] bus_addr_t;
    // byte address inside one 128 word cache.
    typedef logic [8:0]  cache_addr_t;
    typedef logic [3:0]  strobe_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus and fill bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic      wen;
        logic      ren;
        bus_addr_t addr;
        word_t     wdata;
        strobe_t   strobe;
    } bus_req_t;

    typedef struct packed {
        logic        wen;
        logic        ren;
        cache_addr_t addr;
        word_t       wdata;
        strobe_t     strobe;
    } cache_req_t;

    typedef struct packed {
        word_t rdata;
        logic  error;
        logic  request_stall;
    } bus_rsp_t;

    // link side word, qualified by fill_valid / fill_ready.
    typedef struct packed {
        cache_addr_t addr;
        word_t       data;
    } fill_req_t;

endpackage

/* logic/endpoint.sv */
`timescale 1ns/1ns

module endpoint
    import chiplet_types_pkg::*;
    import endpoint_map_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  bus_req_t  req,
    output bus_rsp_t  rsp,
    input  logic      fill_valid,
    output logic      fill_ready,
    input  fill_req_t fill
);

    logic       pkt_hit;
    logic       tx_hit;
    logic       rx_hit;
    logic       pkt_wen;
    logic       pkt_ren;
    word_t      pkt_rdata;
    cache_req_t fwd_req;
    cache_req_t tx_req;
    cache_req_t rx_req;
    bus_rsp_t   tx_rsp;
    bus_rsp_t   rx_rsp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pkt_hit = req.addr < PKT_TABLE_LEN;
    assign tx_hit  = (req.addr >= TX_CACHE_BASE) && (req.addr < TX_CACHE_BASE + CACHE_LEN);
    assign rx_hit  = (req.addr >= RX_CACHE_BASE) && (req.addr < RX_CACHE_BASE + CACHE_LEN);

    always_comb begin
        fwd_req.wen    = req.wen;
        fwd_req.ren    = req.ren;
        fwd_req.addr   = req.addr[$bits(cache_addr_t)-1:0];
        fwd_req.wdata  = req.wdata;
        fwd_req.strobe = req.strobe;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // routing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        tx_req  = '0;
        rx_req  = '0;
        pkt_wen = 1'b0;
        pkt_ren = 1'b0;
        // unmapped default, no error.
        rsp.rdata         = FILLER_WORD;
        rsp.error         = 1'b0;
        rsp.request_stall = 1'b0;

        if (pkt_hit) begin
            pkt_wen   = req.wen;
            pkt_ren   = req.ren;
            rsp.rdata = pkt_rdata;
        end else if (tx_hit) begin
            tx_req = fwd_req;
            rsp    = tx_rsp;
        end else if (rx_hit) begin
            rx_req = fwd_req;
            rsp    = rx_rsp;
        end
    end

    pkt_addr_regs u_pkt_addr_regs (
        .clk   (clk),
        .n_rst (n_rst),
        .wen   (pkt_wen),
        .ren   (pkt_ren),
        .index (req.addr[2 +: $clog2(NUM_MSGS)]),
        .wdata (req.wdata),
        .rdata (pkt_rdata)
    );

    // tx side has no link fill.
    cache tx_cache (
        .clk      (clk),
        .n_rst    (n_rst),
        .req      (tx_req),
        .rsp      (tx_rsp),
        .fill_wen (1'b0),
        .fill     ('0)
    );

    rx_fill_arb u_rx_fill_arb (
        .clk        (clk),
        .n_rst      (n_rst),
        .bus_req    (rx_req),
        .bus_rsp    (rx_rsp),
        .fill_valid (fill_valid),
        .fill_ready (fill_ready),
        .fill       (fill)
    );

endmodule

/* logic/endpoint_map_pkg.sv */
package endpoint_map_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // region sizes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_MSGS        = 4;
    localparam int CACHE_NUM_WORDS = 128;

    // packet table sits at byte address 0.
    localparam int PKT_TABLE_LEN = NUM_MSGS * 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache regions.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] TX_CACHE_BASE = 32'h0000_2000;
    localparam logic [31:0] RX_CACHE_BASE = 32'h0000_3000;
    localparam int          CACHE_LEN     = CACHE_NUM_WORDS * 4;

    // returned for any unmapped read.
    localparam logic [31:0] FILLER_WORD = 32'hBAD1_BAD1;

endpackage

/* logic/pkt_addr_regs.sv */
`timescale 1ns/1ns

module pkt_addr_regs
    import chiplet_types_pkg::*;
    import endpoint_map_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  logic       wen,
    input  logic       ren,
    input  logic [1:0] index,
    input  word_t      wdata,
    output word_t      rdata
);

    word_t pkt_start_addr [NUM_MSGS];
    word_t aligned_wdata;

    // keep only a word aligned cache address.
    assign aligned_wdata = word_t'({wdata[$bits(cache_addr_t)-1:2], 2'b00});

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_MSGS; i++) begin
                pkt_start_addr[i] <= '0;
            end
        end else if (wen) begin
            pkt_start_addr[index] <= aligned_wdata;
        end
    end

    // zero wait read.
    always_comb begin
        if (ren) begin
            rdata = pkt_start_addr[index];
        end else begin
            rdata = '0;
        end
    end

endmodule

/* logic/rx_fill_arb.sv */
`timescale 1ns/1ns

module rx_fill_arb
    import chiplet_types_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,
    input  cache_req_t bus_req,
    output bus_rsp_t   bus_rsp,
    input  logic       fill_valid,
    output logic       fill_ready,
    input  fill_req_t  fill
);

    cache_req_t cache_req;
    bus_rsp_t   cache_rsp;
    logic       bus_active;
    logic       fill_wen;

    // bus master always wins.
    assign bus_active = bus_req.ren || bus_req.wen;
    assign fill_ready = !bus_active;
    assign fill_wen   = fill_valid && fill_ready;

    // master side is read only.
    always_comb begin
        cache_req     = bus_req;
        cache_req.wen = 1'b0;
    end

    always_comb begin
        bus_rsp.rdata         = cache_rsp.rdata;
        bus_rsp.error         = cache_rsp.error || bus_req.wen;
        bus_rsp.request_stall = cache_rsp.request_stall;
    end

    cache rx_cache (
        .clk      (clk),
        .n_rst    (n_rst),
        .req      (cache_req),
        .rsp      (cache_rsp),
        .fill_wen (fill_wen),
        .fill     (fill)
    );

endmodule
